/* common/piso_macros.svh */
`ifndef PISO_MACROS_SVH
`define PISO_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serializer geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Wide input word.
`define PISO_DIN_WIDTH 128

// Narrow output slice.
`define PISO_DOUT_WIDTH 32

// Entries, power of two.
`define PISO_FIFO_DEPTH 8

// Slices per word, power of two.
`define PISO_SLICES ((`PISO_DIN_WIDTH) / (`PISO_DOUT_WIDTH))

`endif

/* common/piso_pkg.sv */
`default_nettype none

`include "piso_macros.svh"

package piso_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath vectors
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [`PISO_DIN_WIDTH-1:0]  din_word_t;   // One wide FIFO word.
    typedef logic [`PISO_DOUT_WIDTH-1:0] dout_word_t;  // One output slice.

    typedef logic [$clog2(`PISO_FIFO_DEPTH)-1:0] fifo_addr_t;
    typedef logic [$clog2(`PISO_FIFO_DEPTH):0]   fifo_ptr_t;   // MSB is the wrap bit.

    typedef logic [$clog2(`PISO_SLICES)-1:0] slice_idx_t;

    // Serializer FSM.
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_BUSY
    } piso_state_t;

endpackage

`default_nettype wire

/* src/bram_infer.sv */
`default_nettype none
`timescale 1ns/1ps

`include "piso_macros.svh"

module bram_infer (
    input  wire                       clk,
    input  wire                       wr_en,
    input  wire                       rd_en,
    input  wire piso_pkg::fifo_addr_t wr_addr,
    input  wire piso_pkg::fifo_addr_t rd_addr,
    input  wire piso_pkg::din_word_t  wr_data,
    output piso_pkg::din_word_t       rd_data
);

    piso_pkg::din_word_t mem [`PISO_FIFO_DEPTH];

    // Write port.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, data one cycle after rd_en.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* piso/piso_fifo_ptrs.sv */
`default_nettype none
`timescale 1ns/1ps

`include "piso_macros.svh"

module piso_fifo_ptrs (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   din_valid,
    input  wire                   rd_en,
    output logic                  wr_en,
    output piso_pkg::fifo_addr_t  wr_addr,
    output piso_pkg::fifo_addr_t  rd_addr,
    output logic                  full,
    output logic                  empty
);

    localparam int ADDR_W = $clog2(`PISO_FIFO_DEPTH);

    piso_pkg::fifo_ptr_t wr_ptr;
    piso_pkg::fifo_ptr_t rd_ptr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign wr_en   = din_valid & ~full;  // Strobe while full is dropped.
    assign wr_addr = wr_ptr[ADDR_W-1:0];
    assign rd_addr = rd_ptr[ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The serializer only reads stored words.
    a_no_read_empty: assert property (
        @(posedge clk) disable iff (rst) rd_en |-> !empty
    ) else $error("read strobe while FIFO empty");

endmodule

`default_nettype wire

/* piso/piso.sv */
`default_nettype none
`timescale 1ns/1ps

`include "piso_macros.svh"

module piso (
    input  wire                       clk,
    input  wire                       rst,
    input  wire piso_pkg::din_word_t  din,
    input  wire                       din_valid,
    output logic                      full,
    output piso_pkg::dout_word_t      dout,
    output logic                      dout_valid,
    input  wire                       dout_ready
);

    piso_pkg::piso_state_t state;
    piso_pkg::din_word_t   rd_data;
    piso_pkg::din_word_t   hold;
    piso_pkg::dout_word_t  dout_r;
    piso_pkg::slice_idx_t  idx;
    piso_pkg::slice_idx_t  idx_next;
    piso_pkg::fifo_addr_t  wr_addr;
    piso_pkg::fifo_addr_t  rd_addr;

    logic wr_en;
    logic rd_en;
    logic empty;
    logic xfer;
    logic last_slice;
    logic dout_valid_r;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // FIFO
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    piso_fifo_ptrs i_ptrs (
        .clk       (clk),
        .rst       (rst),
        .din_valid (din_valid),
        .rd_en     (rd_en),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .rd_addr   (rd_addr),
        .full      (full),
        .empty     (empty)
    );

    bram_infer i_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .rd_en   (rd_en),
        .wr_addr (wr_addr),
        .rd_addr (rd_addr),
        .wr_data (din),
        .rd_data (rd_data)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Load / serialize FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign xfer       = dout_valid_r & dout_ready;
    assign last_slice = (idx == piso_pkg::slice_idx_t'(`PISO_SLICES - 1));
    assign idx_next   = idx + 1'b1;

    // Read on entry from idle, or back to back after the last slice.
    always_comb begin
        case (state)
            piso_pkg::ST_IDLE: rd_en = ~empty;
            piso_pkg::ST_BUSY: rd_en = xfer & last_slice & ~empty;
            default:           rd_en = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= piso_pkg::ST_IDLE;
            idx          <= '0;
            dout_valid_r <= 1'b0;
        end else begin
            case (state)
                piso_pkg::ST_IDLE: begin
                    if (rd_en) begin
                        state <= piso_pkg::ST_LOAD;
                    end
                end
                piso_pkg::ST_LOAD: begin
                    state        <= piso_pkg::ST_BUSY;
                    idx          <= '0;
                    dout_valid_r <= 1'b1;  // Valid the cycle after load.
                end
                piso_pkg::ST_BUSY: begin
                    if (xfer) begin
                        if (last_slice) begin
                            dout_valid_r <= 1'b0;
                            state        <= rd_en ? piso_pkg::ST_LOAD : piso_pkg::ST_IDLE;
                        end else begin
                            idx <= idx_next;
                        end
                    end
                end
                default: state <= piso_pkg::ST_IDLE;
            endcase
        end
    end

    // Holding register and output slice.
    always_ff @(posedge clk) begin
        if (state == piso_pkg::ST_LOAD) begin
            hold   <= rd_data;
            dout_r <= rd_data[`PISO_DOUT_WIDTH-1:0];  // Slice 0 first.
        end else if (xfer && !last_slice) begin
            dout_r <= hold[idx_next * `PISO_DOUT_WIDTH +: `PISO_DOUT_WIDTH];
        end
    end

    assign dout       = dout_r;
    assign dout_valid = dout_valid_r;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_stall_stable: assert property (
        @(posedge clk) disable iff (rst)
        (dout_valid && !dout_ready) |=> (dout_valid && $stable(dout))
    ) else $error("dout changed while stalled");

    a_idle_not_valid: assert property (
        @(posedge clk) disable iff (rst)
        (state == piso_pkg::ST_IDLE) |-> !dout_valid
    ) else $error("dout_valid high in idle");

endmodule

`default_nettype wire

/* src/piso_top.sv */
`default_nettype none
`timescale 1ns/1ps

module piso_top (
    input  wire                       clk,
    input  wire                       rst,
    input  wire piso_pkg::din_word_t  din,
    input  wire                       din_valid,
    output logic                      full,
    output piso_pkg::dout_word_t      dout,
    output logic                      dout_valid,
    input  wire                       dout_ready
);

    // Wide in, narrow out.
    piso i_piso (
        .clk        (clk),
        .rst        (rst),
        .din        (din),
        .din_valid  (din_valid),
        .full       (full),
        .dout       (dout),
        .dout_valid (dout_valid),
        .dout_ready (dout_ready)
    );

endmodule

`default_nettype wire

/* tb/tb_piso_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "piso_macros.svh"

module tb_piso_top;

    localparam int CYCLES_PER_WORD = 64;
    localparam int CYCLES_PER_TEST = 200;
    localparam int IDLE_CYCLES     = 20;
    localparam int MODE_ALWAYS     = 0;
    localparam int MODE_NEVER      = 1;
    localparam int MODE_RANDOM     = 2;

    logic                 clk;
    logic                 rst;
    piso_pkg::din_word_t  din;
    logic                 din_valid;
    logic                 full;
    piso_pkg::dout_word_t dout;
    logic                 dout_valid;
    logic                 dout_ready;

    string                test_name[$];
    int                   test_mode[$];
    int                   test_first[$];
    int                   test_count[$];
    piso_pkg::din_word_t  word_list[$];
    piso_pkg::dout_word_t expected_q[$];   // Slices still owed by the DUT.

    string                cur_test        = "reset";
    int                   ready_mode      = MODE_ALWAYS;
    int                   watchdog_cycles = 0;
    logic                 stalled         = 1'b0;
    piso_pkg::dout_word_t stall_dout;

    piso_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .din        (din),
        .din_valid  (din_valid),
        .full       (full),
        .dout       (dout),
        .dout_valid (dout_valid),
        .dout_ready (dout_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reporting
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_values(input string what,
                                  input logic [`PISO_DIN_WIDTH-1:0] expected,
                                  input logic [`PISO_DIN_WIDTH-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s %s: expected %0h, actual %0h",
                                cur_test, what, expected, actual));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Vector file
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic load_vectors();
        int                  fd;
        string               line;
        string               tag;
        string               name;
        string               mode;
        piso_pkg::din_word_t word;
        fd = $fopen("tb/piso_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("could not open tb/piso_vectors.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            tag  = "";
            void'($fgets(line, fd));
            void'($sscanf(line, "%s", tag));
            if (tag == "test") begin
                void'($sscanf(line, "%s %s %s", tag, name, mode));
                test_name.push_back(name);
                test_first.push_back(word_list.size());
                test_count.push_back(0);
                if (mode == "always") test_mode.push_back(MODE_ALWAYS);
                else if (mode == "never") test_mode.push_back(MODE_NEVER);
                else if (mode == "random") test_mode.push_back(MODE_RANDOM);
                else abort_run($sformatf("test %s has unknown ready mode %s", name, mode));
            end else if (tag == "word") begin
                if (test_count.size() == 0) begin
                    abort_run("vector file has a word before any test");
                end
                void'($sscanf(line, "%s %h", tag, word));
                word_list.push_back(word);
                test_count[test_count.size()-1]++;
            end else if (tag != "" && tag != "#") begin
                abort_run($sformatf("vector file has an unknown line: %s", line));
            end
        end
        $fclose(fd);
        if (test_name.size() == 0) begin
            abort_run("vector file holds no tests");
        end
        watchdog_cycles = CYCLES_PER_WORD * word_list.size() +
                          CYCLES_PER_TEST * test_name.size();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Ready driver and monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        if (ready_mode == MODE_NEVER) dout_ready <= 1'b0;
        else if (ready_mode == MODE_RANDOM) dout_ready <= ($urandom % 2) == 1;
        else dout_ready <= 1'b1;
    end

    // Sampled mid-cycle, so these are the values the next edge sees.
    always @(negedge clk) begin : monitor
        int s;
        if (!rst) begin
            if (stalled) begin
                compare_values("dout_valid while stalled", 1, dout_valid);
                compare_values("dout while stalled", stall_dout, dout);
            end
            if (din_valid && !full) begin
                for (s = 0; s < `PISO_SLICES; s++) begin
                    expected_q.push_back(din[s*`PISO_DOUT_WIDTH +: `PISO_DOUT_WIDTH]);
                end
            end
            if (dout_valid && dout_ready) begin
                if (expected_q.size() == 0) begin
                    abort_run($sformatf("%s: slice %0h came out with no word left to send",
                                        cur_test, dout));
                end
                compare_values("slice", expected_q.pop_front(), dout);
            end
            stalled    = dout_valid && !dout_ready;
            stall_dout = dout;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic run_test(input int t);
        int w;
        cur_test   = test_name[t];
        ready_mode = test_mode[t];
        for (w = 0; w < test_count[t]; w++) begin
            @(posedge clk);
            din       <= word_list[test_first[t] + w];
            din_valid <= 1'b1;
        end
        @(posedge clk);
        din_valid <= 1'b0;
        if (ready_mode == MODE_NEVER && test_count[t] > `PISO_FIFO_DEPTH) begin
            repeat (4) @(negedge clk);
            compare_values("full while blocked", 1, full);
            compare_values("words dropped", 1,
                           expected_q.size() < test_count[t] * `PISO_SLICES);
            ready_mode = MODE_ALWAYS;
        end
        @(negedge clk);
        while (expected_q.size() != 0 || dout_valid) @(negedge clk);
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            compare_values("dout_valid when drained", 0, dout_valid);
        end
        compare_values("full when drained", 0, full);
    endtask

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        abort_run($sformatf("timed out after %0d cycles before all tests finished",
                            watchdog_cycles));
    end

    initial begin : main
        int t;
        rst        = 1'b1;
        din        = '0;
        din_valid  = 1'b0;
        dout_ready = 1'b1;
        void'($urandom(18));
        load_vectors();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_values("dout_valid after reset", 0, dout_valid);
        compare_values("full after reset", 0, full);
        for (t = 0; t < test_name.size(); t++) begin
            run_test(t);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/piso_vectors.txt */
# test <name> <ready mode: always, never or random>
# word <128-bit input word in hex>, one line per word of the test above
test reset_idle always
test single_word always
word 11110003111100021111000111110000
test burst_six always
word b0000003b0000002b0000001b0000000
word b0010003b0010002b0010001b0010000
word b0020003b0020002b0020001b0020000
word b0030003b0030002b0030001b0030000
word b0040003b0040002b0040001b0040000
word b0050003b0050002b0050001b0050000
test random_ready random
word c0000003c0000002c0000001c0000000
word c0010003c0010002c0010001c0010000
word c0020003c0020002c0020001c0020000
word c0030003c0030002c0030001c0030000
word c0040003c0040002c0040001c0040000
word c0050003c0050002c0050001c0050000
word c0060003c0060002c0060001c0060000
word c0070003c0070002c0070001c0070000
word c0080003c0080002c0080001c0080000
word c0090003c0090002c0090001c0090000
word c00a0003c00a0002c00a0001c00a0000
word c00b0003c00b0002c00b0001c00b0000
word c00c0003c00c0002c00c0001c00c0000
word c00d0003c00d0002c00d0001c00d0000
word c00e0003c00e0002c00e0001c00e0000
word c00f0003c00f0002c00f0001c00f0000
word c0100003c0100002c0100001c0100000
word c0110003c0110002c0110001c0110000
word c0120003c0120002c0120001c0120000
word c0130003c0130002c0130001c0130000
test full_drop never
word d0000003d0000002d0000001d0000000
word d0010003d0010002d0010001d0010000
word d0020003d0020002d0020001d0020000
word d0030003d0030002d0030001d0030000
word d0040003d0040002d0040001d0040000
word d0050003d0050002d0050001d0050000
word d0060003d0060002d0060001d0060000
word d0070003d0070002d0070001d0070000
word d0080003d0080002d0080001d0080000
word d0090003d0090002d0090001d0090000

/* piso_serdes.f */
+incdir+common
common/piso_pkg.sv
src/bram_infer.sv
piso/piso_fifo_ptrs.sv
piso/piso.sv
src/piso_top.sv
tb/tb_piso_top.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f piso_serdes.f --top-module tb_piso_top

out=$(./obj_dir/Vtb_piso_top) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Simulation finished: PASS'; then
    exit 0
else
    exit 1
fi
